// ==== include/ring_cfg.svh ====
`ifndef RING_CFG_SVH
`define RING_CFG_SVH

// --------------------------------------------------
// flit geometry
// msb first: vc, dir, rsvd, hop, src, payload
// --------------------------------------------------
`define RING_FLIT_W  64
`define RING_VC_BIT  63

// 0 clockwise, 1 counter-clockwise
`define RING_DIR_BIT 62

// hop count, one bit per remaining hop
`define RING_HOP_LSB 48
`define RING_HOP_W   8

// source id, carried along untouched
`define RING_SRC_LSB 32

// even and odd channel per port
`define RING_NUM_VC  2

`endif

// ==== source/ring_pkg.sv ====
`include "ring_cfg.svh"

package ring_pkg;

    // --------------------------------------------------
    // flit and link
    // --------------------------------------------------

    // field widths follow from the edges in ring_cfg.svh
    typedef struct packed {
        logic [`RING_FLIT_W-`RING_VC_BIT-1:0]                  vc;
        logic [`RING_VC_BIT-`RING_DIR_BIT-1:0]                 dir;
        logic [`RING_DIR_BIT-`RING_HOP_LSB-`RING_HOP_W-1:0]    rsvd;
        logic [`RING_HOP_W-1:0]                                hop;
        logic [`RING_HOP_LSB-`RING_SRC_LSB-1:0]                src;
        logic [`RING_SRC_LSB-1:0]                              payload;
    } flit_t;

    // what a neighbour presents on one input port
    typedef struct packed {
        flit_t data;
        logic  send;
    } link_in_t;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------

    // legal hop codes at injection from the pe
    typedef enum logic [`RING_HOP_W-1:0] {
        HOP_ONE   = 8'b0000_0001,
        HOP_TWO   = 8'b0000_0011,
        HOP_THREE = 8'b0000_0111
    } hop_code_e;

    // port index for per-port arrays
    typedef enum logic [1:0] {
        PORT_CW  = 2'd0,
        PORT_CCW = 2'd1,
        PORT_PE  = 2'd2
    } port_e;

    // round-robin pointer, one per output and channel
    typedef enum logic {
        FAVOR_A = 1'b0,
        FAVOR_B = 1'b1
    } rr_state_e;

endpackage

// ==== source/inject_decode.sv ====
`timescale 1ns/1ps

module inject_decode
    import ring_pkg::*;
(
    input  link_in_t pe_in,
    output link_in_t pe_checked
);

    // --------------------------------------------------
    // hop code check on packets entering from the pe
    // --------------------------------------------------

    always_comb begin
        // default is pass through
        pe_checked = pe_in;

        case (pe_in.data.hop)
            HOP_ONE: begin
                // single hop, nothing to fix
            end

            HOP_TWO: begin
                // two hops always go clockwise
                pe_checked.data.dir = 1'b0;
            end

            HOP_THREE: begin
                // three hops one way is one hop the other way
                pe_checked.data.dir = ~pe_in.data.dir;
                pe_checked.data.hop = HOP_ONE;
            end

            default: begin
                // bad code, drop without touching a buffer
                pe_checked.send = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/vc_input_stage.sv ====
`timescale 1ns/1ps
`include "ring_cfg.svh"

module vc_input_stage
    import ring_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    polarity,
    input  link_in_t                link,
    output logic                    ready,
    output flit_t                   flit [`RING_NUM_VC],
    output logic [`RING_NUM_VC-1:0] full,
    input  logic [`RING_NUM_VC-1:0] take
);

    logic                    wr_en;
    logic [`RING_NUM_VC-1:0] wr_mask;
    flit_t                   wr_flit;

    // --------------------------------------------------
    // link side
    // --------------------------------------------------

    // ready only reflects the channel facing the link now
    assign ready = ~full[polarity];
    assign wr_en = link.send & ready;

    // stamp the channel the packet arrived on
    always_comb begin
        wr_flit    = link.data;
        wr_flit.vc = polarity;
    end

    always_comb begin
        for (int v = 0; v < `RING_NUM_VC; v++) begin
            wr_mask[v] = wr_en && (polarity == 1'(v));
        end
    end

    // --------------------------------------------------
    // one-entry buffers
    // --------------------------------------------------

    // take only hits the inactive channel, write the active one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= '0;
        end else begin
            full <= (full & ~take) | wr_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            flit[polarity] <= wr_flit;
        end
    end

endmodule

// ==== source/route_arbiter.sv ====
`timescale 1ns/1ps
`include "ring_cfg.svh"

module route_arbiter
    import ring_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    polarity,
    input  flit_t                   in_flit [3][`RING_NUM_VC],
    input  logic [`RING_NUM_VC-1:0] in_full [3],
    output logic [`RING_NUM_VC-1:0] in_take [3],
    output flit_t                   out_flit [3][`RING_NUM_VC],
    output logic [`RING_NUM_VC-1:0] out_put [3],
    input  logic [`RING_NUM_VC-1:0] out_empty [3]
);

    logic [`RING_NUM_VC-1:0] gnt_a [3];
    logic [`RING_NUM_VC-1:0] gnt_b [3];

    // --------------------------------------------------
    // routing helpers
    // --------------------------------------------------

    // the two inputs that compete for an output
    function automatic port_e contender(port_e dst, logic second);
        port_e src;
        case (dst)
            PORT_CW:  src = second ? PORT_PE : PORT_CW;
            PORT_CCW: src = second ? PORT_PE : PORT_CCW;
            default:  src = second ? PORT_CCW : PORT_CW;
        endcase
        return src;
    endfunction

    // ring traffic keeps going or ejects, pe traffic follows dir
    function automatic port_e route_of(port_e src, flit_t f);
        port_e dst;
        if (src == PORT_PE) begin
            dst = f.dir[0] ? PORT_CCW : PORT_CW;
        end else if (f.hop[0]) begin
            dst = src;
        end else begin
            dst = PORT_PE;
        end
        return dst;
    endfunction

    // one hop consumed per transfer
    function automatic flit_t hop_shift(flit_t f);
        flit_t r;
        r     = f;
        r.hop = f.hop >> 1;
        return r;
    endfunction

    // --------------------------------------------------
    // per output, per channel arbitration
    // --------------------------------------------------
    for (genvar v = 0; v < `RING_NUM_VC; v++) begin : g_vc
        for (genvar o = 0; o < 3; o++) begin : g_out
            localparam port_e SRC_A = contender(port_e'(o), 1'b0);
            localparam port_e SRC_B = contender(port_e'(o), 1'b1);

            logic      sw_active;
            logic      req_a;
            logic      req_b;
            rr_state_e favor_q;

            // switch a channel only while it is off the links
            assign sw_active = (polarity != 1'(v)) & out_empty[o][v];

            assign req_a = sw_active & in_full[SRC_A][v] &
                           (route_of(SRC_A, in_flit[SRC_A][v]) == port_e'(o));
            assign req_b = sw_active & in_full[SRC_B][v] &
                           (route_of(SRC_B, in_flit[SRC_B][v]) == port_e'(o));

            // a lone request wins outright
            assign gnt_a[o][v] = req_a & (~req_b | (favor_q == FAVOR_A));
            assign gnt_b[o][v] = req_b & ~gnt_a[o][v];

            assign out_put[o][v]  = gnt_a[o][v] | gnt_b[o][v];
            assign out_flit[o][v] = gnt_a[o][v] ? hop_shift(in_flit[SRC_A][v])
                                                : hop_shift(in_flit[SRC_B][v]);

            // favor flips only on a real conflict
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    favor_q <= FAVOR_A;
                end else if (req_a && req_b) begin
                    favor_q <= gnt_a[o][v] ? FAVOR_B : FAVOR_A;
                end
            end
        end
    end

    // --------------------------------------------------
    // read strobes back to the inputs
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            in_take[i] = '0;
        end
        // an input targets one output, so at most one grant per input
        for (int o = 0; o < 3; o++) begin
            in_take[contender(port_e'(o), 1'b0)] |= gnt_a[o];
            in_take[contender(port_e'(o), 1'b1)] |= gnt_b[o];
        end
    end

endmodule

// ==== source/output_stage.sv ====
`timescale 1ns/1ps
`include "ring_cfg.svh"

module output_stage
    import ring_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    polarity,
    input  flit_t                   flit_in [`RING_NUM_VC],
    input  logic [`RING_NUM_VC-1:0] put,
    output logic [`RING_NUM_VC-1:0] empty,
    output flit_t                   data,
    output logic                    so,
    input  logic                    ro
);

    logic [`RING_NUM_VC-1:0] full_q;
    logic [`RING_NUM_VC-1:0] pop_mask;
    flit_t                   buf_q [`RING_NUM_VC];

    // --------------------------------------------------
    // link side
    // --------------------------------------------------

    // so comes from the buffer alone, never from ro
    assign so    = full_q[polarity];
    assign data  = buf_q[polarity];
    assign empty = ~full_q;

    // handshake completes on so and ro together
    always_comb begin
        for (int v = 0; v < `RING_NUM_VC; v++) begin
            pop_mask[v] = so && ro && (polarity == 1'(v));
        end
    end

    // --------------------------------------------------
    // one-entry buffers
    // --------------------------------------------------

    // put lands on the inactive channel, pop on the active one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= '0;
        end else begin
            full_q <= (full_q & ~pop_mask) | put;
        end
    end

    always_ff @(posedge clk) begin
        for (int v = 0; v < `RING_NUM_VC; v++) begin
            if (put[v]) begin
                buf_q[v] <= flit_in[v];
            end
        end
    end

endmodule

// ==== source/gold_router.sv ====
`timescale 1ns/1ps
`include "ring_cfg.svh"

module gold_router
    import ring_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     polarity,
    // inputs from the neighbours and the pe
    input  link_in_t cw_in,
    input  link_in_t ccw_in,
    input  link_in_t pe_in,
    output logic     cwri,
    output logic     ccwri,
    output logic     peri,
    // outputs towards the neighbours and the pe
    output flit_t    cwdo,
    output flit_t    ccwdo,
    output flit_t    pedo,
    output logic     cwso,
    output logic     ccwso,
    output logic     peso,
    input  logic     cwro,
    input  logic     ccwro,
    input  logic     pero
);

    link_in_t                pe_checked;
    flit_t                   in_flit [3][`RING_NUM_VC];
    logic [`RING_NUM_VC-1:0] in_full [3];
    logic [`RING_NUM_VC-1:0] in_take [3];
    flit_t                   out_flit [3][`RING_NUM_VC];
    logic [`RING_NUM_VC-1:0] out_put [3];
    logic [`RING_NUM_VC-1:0] out_empty [3];

    // --------------------------------------------------
    // injection decode and input buffers
    // --------------------------------------------------
    inject_decode u_inject (
        .pe_in      (pe_in),
        .pe_checked (pe_checked)
    );

    vc_input_stage u_cw_in (
        .clk      (clk),
        .arst_n   (arst_n),
        .polarity (polarity),
        .link     (cw_in),
        .ready    (cwri),
        .flit     (in_flit[PORT_CW]),
        .full     (in_full[PORT_CW]),
        .take     (in_take[PORT_CW])
    );

    vc_input_stage u_ccw_in (
        .clk      (clk),
        .arst_n   (arst_n),
        .polarity (polarity),
        .link     (ccw_in),
        .ready    (ccwri),
        .flit     (in_flit[PORT_CCW]),
        .full     (in_full[PORT_CCW]),
        .take     (in_take[PORT_CCW])
    );

    // pe sees the checked packet, dropped ones never write
    vc_input_stage u_pe_in (
        .clk      (clk),
        .arst_n   (arst_n),
        .polarity (polarity),
        .link     (pe_checked),
        .ready    (peri),
        .flit     (in_flit[PORT_PE]),
        .full     (in_full[PORT_PE]),
        .take     (in_take[PORT_PE])
    );

    // --------------------------------------------------
    // switch
    // --------------------------------------------------
    route_arbiter u_switch (
        .clk       (clk),
        .arst_n    (arst_n),
        .polarity  (polarity),
        .in_flit   (in_flit),
        .in_full   (in_full),
        .in_take   (in_take),
        .out_flit  (out_flit),
        .out_put   (out_put),
        .out_empty (out_empty)
    );

    // --------------------------------------------------
    // output buffers
    // --------------------------------------------------
    output_stage u_cw_out (
        .clk      (clk),
        .arst_n   (arst_n),
        .polarity (polarity),
        .flit_in  (out_flit[PORT_CW]),
        .put      (out_put[PORT_CW]),
        .empty    (out_empty[PORT_CW]),
        .data     (cwdo),
        .so       (cwso),
        .ro       (cwro)
    );

    output_stage u_ccw_out (
        .clk      (clk),
        .arst_n   (arst_n),
        .polarity (polarity),
        .flit_in  (out_flit[PORT_CCW]),
        .put      (out_put[PORT_CCW]),
        .empty    (out_empty[PORT_CCW]),
        .data     (ccwdo),
        .so       (ccwso),
        .ro       (ccwro)
    );

    // ejection port
    output_stage u_pe_out (
        .clk      (clk),
        .arst_n   (arst_n),
        .polarity (polarity),
        .flit_in  (out_flit[PORT_PE]),
        .put      (out_put[PORT_PE]),
        .empty    (out_empty[PORT_PE]),
        .data     (pedo),
        .so       (peso),
        .ro       (pero)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset low for a few rising edges, released on an edge
    initial begin
        arst_n <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== tests/gold_router_assert.sv ====
`timescale 1ns/1ps

module gold_router_assert
    import ring_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  polarity,
    input flit_t cwdo,
    input flit_t ccwdo,
    input flit_t pedo,
    input logic  cwso,
    input logic  ccwso,
    input logic  peso,
    input logic  cwri,
    input logic  ccwri,
    input logic  peri,
    input flit_t cw_buf0,
    input flit_t cw_buf1,
    input flit_t ccw_buf0,
    input flit_t ccw_buf1,
    input flit_t pe_buf0,
    input flit_t pe_buf1
);

    // --------------------------------------------------
    // outputs only send the channel facing the link
    // --------------------------------------------------
    a_cw_vc: assert property (@(posedge clk) disable iff (!arst_n)
        cwso |-> cwdo.vc == polarity)
        else $error("cw output sent a flit of the idle channel");

    a_ccw_vc: assert property (@(posedge clk) disable iff (!arst_n)
        ccwso |-> ccwdo.vc == polarity)
        else $error("ccw output sent a flit of the idle channel");

    a_pe_vc: assert property (@(posedge clk) disable iff (!arst_n)
        peso |-> pedo.vc == polarity)
        else $error("pe output sent a flit of the idle channel");

    // nothing buffered in the first cycle out of reset
    a_quiet: assert property (@(posedge clk)
        $rose(arst_n) |-> !(cwso || ccwso || peso))
        else $error("send raised right after reset release");

    // --------------------------------------------------
    // full input buffer is never overwritten
    // --------------------------------------------------

    // held-off buffer keeps its flit through the edge
    a_cw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !cwri |=> ($past(polarity) ? $stable(cw_buf1) : $stable(cw_buf0)))
        else $error("cw input written while not ready");

    a_ccw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !ccwri |=> ($past(polarity) ? $stable(ccw_buf1) : $stable(ccw_buf0)))
        else $error("ccw input written while not ready");

    a_pe_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !peri |=> ($past(polarity) ? $stable(pe_buf1) : $stable(pe_buf0)))
        else $error("pe input written while not ready");

endmodule

bind gold_router gold_router_assert u_assert (
    .clk      (clk),
    .arst_n   (arst_n),
    .polarity (polarity),
    .cwdo     (cwdo),
    .ccwdo    (ccwdo),
    .pedo     (pedo),
    .cwso     (cwso),
    .ccwso    (ccwso),
    .peso     (peso),
    .cwri     (cwri),
    .ccwri    (ccwri),
    .peri     (peri),
    .cw_buf0  (u_cw_in.flit[0]),
    .cw_buf1  (u_cw_in.flit[1]),
    .ccw_buf0 (u_ccw_in.flit[0]),
    .ccw_buf1 (u_ccw_in.flit[1]),
    .pe_buf0  (u_pe_in.flit[0]),
    .pe_buf1  (u_pe_in.flit[1])
);

// ==== tests/tb_gold_router.sv ====
`timescale 1ns/1ps

module tb_gold_router
    import ring_pkg::*;
();

    localparam int NUM_PKT   = 600;
    localparam int LAT_MAX   = 24;
    localparam int DRAIN_MAX = 400;

    // accepted packet as it should show up at its exit
    typedef struct packed {
        flit_t      f;
        logic [1:0] src;
        logic [1:0] dst;
        int         cyc;
        logic       strict;
    } sb_entry_t;

    logic        clk;
    logic        arst_n;
    logic        polarity;
    link_in_t    link [3];
    logic        ri [3];
    flit_t       dout [3];
    logic        so [3];
    logic        ro [3];

    sb_entry_t   pend [$];
    logic        taken [3];
    int          ro_len [3];
    int          served [3][3];
    integer      seed;
    logic [31:0] payload_cnt;
    int          pkt_cnt;
    int          cycle;
    int          check_cnt;
    int          err_cnt;
    logic        hold_high;
    int          hold_start;

    tb_clock_gen u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    gold_router i_gold_router (
        .clk      (clk),
        .arst_n   (arst_n),
        .polarity (polarity),
        .cw_in    (link[PORT_CW]),
        .ccw_in   (link[PORT_CCW]),
        .pe_in    (link[PORT_PE]),
        .cwri     (ri[PORT_CW]),
        .ccwri    (ri[PORT_CCW]),
        .peri     (ri[PORT_PE]),
        .cwdo     (dout[PORT_CW]),
        .ccwdo    (dout[PORT_CCW]),
        .pedo     (dout[PORT_PE]),
        .cwso     (so[PORT_CW]),
        .ccwso    (so[PORT_CCW]),
        .peso     (so[PORT_PE]),
        .cwro     (ro[PORT_CW]),
        .ccwro    (ro[PORT_CCW]),
        .pero     (ro[PORT_PE])
    );

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // injection rule on pe packets, routing rule, then one hop shift
    function automatic logic predict(input int src, input flit_t f, input logic pol,
                                     output int dst, output flit_t exp);
        logic kept;
        kept   = 1'b1;
        exp    = f;
        exp.vc = pol;
        if (src == PORT_PE) begin
            case (f.hop)
                8'h01: exp.dir = f.dir;
                8'h03: exp.dir = 1'b0;
                8'h07: begin
                    exp.dir = ~f.dir;
                    exp.hop = 8'h01;
                end
                default: kept = 1'b0;
            endcase
            dst = exp.dir ? PORT_CCW : PORT_CW;
        end else begin
            // bit 0 clear means this node is the target
            dst = f.hop[0] ? src : PORT_PE;
        end
        exp.hop = exp.hop >> 1;
        return kept;
    endfunction

    // random fields, pe hop codes mostly legal, payload unique
    function automatic flit_t new_flit(input int p);
        flit_t      f;
        logic [2:0] pick;
        f    = {$random(seed), $random(seed)};
        pick = 3'($random(seed));
        if (p == PORT_PE) begin
            case (pick)
                3'd0, 3'd1: f.hop = 8'h01;
                3'd2, 3'd3: f.hop = 8'h03;
                3'd4, 3'd5: f.hop = 8'h07;
                // random code, nearly always illegal
                default: ;
            endcase
        end
        f.payload   = payload_cnt;
        payload_cnt = payload_cnt + 1;
        return f;
    endfunction

    task automatic record_packet(input int p);
        sb_entry_t e;
        flit_t     exp;
        int        dst;
        if (predict(p, link[p].data, polarity, dst, exp)) begin
            e.f      = exp;
            e.src    = 2'(p);
            e.dst    = 2'(dst);
            e.cyc    = cycle;
            e.strict = hold_high && (cycle - hold_start >= 8);
            pend.push_back(e);
        end
    endtask

    // match by payload, sources may overtake each other
    task automatic retire_packet(input int p);
        int idx;
        idx = -1;
        foreach (pend[i]) begin
            if (pend[i].dst == 2'(p) && pend[i].f.payload == dout[p].payload) begin
                idx = i;
            end
        end
        check_value(idx >= 0, 1, $sformatf("payload %h known at port %0d",
                                           dout[p].payload, p));
        if (idx >= 0) begin
            check_value(dout[p], pend[idx].f, $sformatf("flit at port %0d", p));
            if (pend[idx].strict) begin
                check_value(cycle - pend[idx].cyc <= LAT_MAX, 1, "latency with ro high");
                served[p][pend[idx].src]++;
            end
            pend.delete(idx);
        end
    endtask

    function automatic int count_pending(input int p);
        int n;
        n = 0;
        foreach (pend[i]) begin
            if (pend[i].dst == 2'(p)) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic logic traffic_pending();
        return pend.size() != 0 || link[0].send || link[1].send || link[2].send;
    endfunction

    // --------------------------------------------------
    // stimulus on the rising edge, monitor on the falling
    // --------------------------------------------------
    always @(posedge clk) begin
        polarity <= ~polarity;
        if (arst_n) begin
            // second half runs with every receiver ready
            if (!hold_high && pkt_cnt >= NUM_PKT / 2) begin
                hold_high  = 1'b1;
                hold_start = cycle;
            end
            for (int p = 0; p < 3; p++) begin
                // sender holds its packet until ri takes it
                if (taken[p] || !link[p].send) begin
                    if (pkt_cnt < NUM_PKT && ($random(seed) & 3) != 0) begin
                        link[p] <= {new_flit(p), 1'b1};
                        pkt_cnt++;
                    end else begin
                        link[p].send <= 1'b0;
                    end
                end
                // receivers stall in random stretches, some long
                if (hold_high) begin
                    ro[p] <= 1'b1;
                end else if (ro_len[p] == 0) begin
                    ro[p]     <= 1'($random(seed));
                    ro_len[p] = $random(seed) & 31;
                end else begin
                    ro_len[p]--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            cycle++;
            for (int p = 0; p < 3; p++) begin
                taken[p] = link[p].send && ri[p];
                if (taken[p]) begin
                    record_packet(p);
                end
                if (so[p]) begin
                    check_value(dout[p].vc, polarity, "sent flit vc equals polarity");
                    if (ro[p]) begin
                        retire_packet(p);
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // sequence and end of run
    // --------------------------------------------------
    initial begin
        repeat (NUM_PKT * 40) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", NUM_PKT * 40);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int n;
        seed        = 32'h44953249;
        polarity    <= 1'b0;
        payload_cnt = '0;
        pkt_cnt     = 0;
        cycle       = 0;
        check_cnt   = 0;
        err_cnt     = 0;
        hold_high   = 1'b0;
        hold_start  = 0;
        for (int p = 0; p < 3; p++) begin
            link[p]   <= '0;
            ro[p]     <= 1'b0;
            ro_len[p] = 0;
            taken[p]  = 1'b0;
            for (int q = 0; q < 3; q++) begin
                served[p][q] = 0;
            end
        end

        // idle state one cycle out of reset
        @(posedge arst_n);
        @(negedge clk);
        for (int p = 0; p < 3; p++) begin
            check_value(so[p], 1'b0, $sformatf("so of port %0d after reset", p));
            check_value(ri[p], 1'b1, $sformatf("ri of port %0d after reset", p));
        end

        // all packets out, then drain with ro held high
        wait (pkt_cnt >= NUM_PKT);
        n = 0;
        while (traffic_pending() && n < DRAIN_MAX) begin
            @(posedge clk);
            n++;
        end
        for (int p = 0; p < 3; p++) begin
            check_value(count_pending(p), 0, $sformatf("packets left for port %0d", p));
        end

        // both contenders of every output got through
        check_value(served[PORT_CW][PORT_CW] > 0, 1, "cw output served cw input");
        check_value(served[PORT_CW][PORT_PE] > 0, 1, "cw output served pe input");
        check_value(served[PORT_CCW][PORT_CCW] > 0, 1, "ccw output served ccw input");
        check_value(served[PORT_CCW][PORT_PE] > 0, 1, "ccw output served pe input");
        check_value(served[PORT_PE][PORT_CW] > 0, 1, "pe output served cw input");
        check_value(served[PORT_PE][PORT_CCW] > 0, 1, "pe output served ccw input");

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
source/ring_pkg.sv
source/inject_decode.sv
source/vc_input_stage.sv
source/route_arbiter.sv
source/output_stage.sv
source/gold_router.sv
tests/tb_clock_gen.sv
tests/gold_router_assert.sv
tests/tb_gold_router.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gold_router
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
